// File: common/kbd_defines.svh
`ifndef KBD_DEFINES_SVH
`define KBD_DEFINES_SVH

// PS/2 set 2 prefix sent before the code of a released key
`define KBD_BREAK_CODE 8'hF0

// flip-flops between the PS/2 pins and the receiver logic
`define KBD_SYNC_STAGES 2

// active-low pattern with every segment and the point off
`define SEG_BLANK 8'hFF

`endif

// File: common/kbd_pkg.sv
package kbd_pkg;

    // one byte as it arrives in a PS/2 frame
    typedef logic [7:0] scan_code_t;

    // ASCII of a digit key or 00 for any other key
    typedef logic [7:0] ascii_t;

    // number of make/break pairs seen since reset
    typedef logic [7:0] release_count_t;

    // frame receiver states
    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        CHECK,
        HOLD
    } rx_state_t;

endpackage

// File: common/disp_pkg.sv
package disp_pkg;

    // value shown on one digit
    typedef logic [3:0] hex_t;

    // bit 4 set means the digit is dark, bits 3:0 hold a hex_t
    typedef logic [4:0] digit_t;

    // active low, bits 6:0 are segments g..a, bit 7 is the point
    typedef logic [7:0] seg_t;

endpackage

// File: ps2_rx/ps2_rx.sv
`timescale 1ns/1ns
`include "kbd_defines.svh"

module ps2_rx (
    input  logic                clk,
    input  logic                rst,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output kbd_pkg::scan_code_t code,
    output logic                code_valid,
    input  logic                code_ready,
    output logic                frame_err
);

    localparam int sync_top = `KBD_SYNC_STAGES - 1;

    logic [sync_top:0]  clk_sync;
    logic [sync_top:0]  data_sync;
    logic               clk_prev;
    logic               clk_fall;
    logic [10:0]        frame;
    logic [3:0]         bit_cnt;
    logic               frame_ok;
    kbd_pkg::rx_state_t state;

    // both lines idle high, so the chain resets to ones
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync <= '1;
            data_sync <= '1;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[sync_top-1:0], ps2_clk};
            data_sync <= {data_sync[sync_top-1:0], ps2_data};
            clk_prev <= clk_sync[sync_top];
        end
    end

    assign clk_fall = clk_prev && !clk_sync[sync_top];

    // frame[0] start, frame[8:1] data, frame[9] parity, frame[10] stop
    assign frame_ok = !frame[0] && (^frame[9:1]) && frame[10];

    assign code_valid = (state == kbd_pkg::HOLD);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= kbd_pkg::IDLE;
            bit_cnt <= '0;
            frame_err <= 1'b0;
        end else begin
            frame_err <= 1'b0;
            case (state)
                kbd_pkg::IDLE: begin
                    if (clk_fall) begin
                        bit_cnt <= 4'd1;
                        state <= kbd_pkg::SHIFT;
                    end
                end
                kbd_pkg::SHIFT: begin
                    if (clk_fall) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        // this edge carries the stop bit
                        if (bit_cnt == 4'd10) begin
                            state <= kbd_pkg::CHECK;
                        end
                    end
                end
                kbd_pkg::CHECK: begin
                    if (frame_ok) begin
                        state <= kbd_pkg::HOLD;
                    end else begin
                        frame_err <= 1'b1;
                        state <= kbd_pkg::IDLE;
                    end
                end
                kbd_pkg::HOLD: begin
                    // edges seen here are ignored until the byte is taken
                    if (code_ready) begin
                        state <= kbd_pkg::IDLE;
                    end
                end
                default: begin
                    state <= kbd_pkg::IDLE;
                end
            endcase
        end
    end

    // LSB arrives first, shift towards bit 0
    always_ff @(posedge clk) begin
        if (clk_fall && (state == kbd_pkg::IDLE || state == kbd_pkg::SHIFT)) begin
            frame <= {data_sync[sync_top], frame[10:1]};
        end
        if (state == kbd_pkg::CHECK && frame_ok) begin
            code <= frame[8:1];
        end
    end

endmodule

// File: verilog/key_event.sv
`timescale 1ns/1ns
`include "kbd_defines.svh"

module key_event (
    input  logic                clk,
    input  logic                rst,
    input  kbd_pkg::scan_code_t code,
    input  logic                code_valid,
    output logic                code_ready,
    output kbd_pkg::scan_code_t last_code,
    output disp_pkg::digit_t    scan_lo,
    output disp_pkg::digit_t    scan_hi,
    output disp_pkg::digit_t    ascii_lo,
    output disp_pkg::digit_t    ascii_hi,
    output disp_pkg::digit_t    count_lo,
    output disp_pkg::digit_t    count_hi
);

    localparam disp_pkg::digit_t digit_blank = 5'h10;

    logic                    take;
    logic                    new_is_break;
    logic                    prev_is_break;
    kbd_pkg::ascii_t         ascii;
    kbd_pkg::release_count_t release_count;
    kbd_pkg::release_count_t count_next;

    // digit row of the main key block only
    function automatic kbd_pkg::ascii_t to_ascii(input kbd_pkg::scan_code_t sc);
        case (sc)
            8'h45:   to_ascii = 8'h30;
            8'h16:   to_ascii = 8'h31;
            8'h1E:   to_ascii = 8'h32;
            8'h26:   to_ascii = 8'h33;
            8'h25:   to_ascii = 8'h34;
            8'h2E:   to_ascii = 8'h35;
            8'h36:   to_ascii = 8'h36;
            8'h3D:   to_ascii = 8'h37;
            8'h3E:   to_ascii = 8'h38;
            8'h46:   to_ascii = 8'h39;
            default: to_ascii = 8'h00;
        endcase
    endfunction

    // always ready, so a held byte never waits more than one cycle
    assign code_ready = !rst;
    assign take = code_valid && code_ready;

    assign new_is_break = (code == `KBD_BREAK_CODE);
    assign prev_is_break = (last_code == `KBD_BREAK_CODE);
    assign ascii = to_ascii(code);
    assign count_next = release_count + 8'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_code <= '0;
            release_count <= '0;
            scan_lo <= digit_blank;
            scan_hi <= digit_blank;
            ascii_lo <= digit_blank;
            ascii_hi <= digit_blank;
            count_lo <= '0;
            count_hi <= '0;
        end else if (take) begin
            last_code <= code;
            if (new_is_break) begin
                scan_lo <= digit_blank;
                scan_hi <= digit_blank;
                ascii_lo <= digit_blank;
                ascii_hi <= digit_blank;
            end else if (prev_is_break) begin
                // code after F0 names the released key
                release_count <= count_next;
                count_lo <= {1'b0, count_next[3:0]};
                count_hi <= {1'b0, count_next[7:4]};
            end else begin
                scan_lo <= {1'b0, code[3:0]};
                scan_hi <= {1'b0, code[7:4]};
                ascii_lo <= {1'b0, ascii[3:0]};
                ascii_hi <= {1'b0, ascii[7:4]};
            end
        end
    end

endmodule

// File: verilog/seg_display.sv
`timescale 1ns/1ns
`include "kbd_defines.svh"

module seg_display (
    input  disp_pkg::digit_t scan_lo,
    input  disp_pkg::digit_t scan_hi,
    input  disp_pkg::digit_t ascii_lo,
    input  disp_pkg::digit_t ascii_hi,
    input  disp_pkg::digit_t count_lo,
    input  disp_pkg::digit_t count_hi,
    output disp_pkg::seg_t   seg0,
    output disp_pkg::seg_t   seg1,
    output disp_pkg::seg_t   seg2,
    output disp_pkg::seg_t   seg3,
    output disp_pkg::seg_t   seg4,
    output disp_pkg::seg_t   seg5,
    output disp_pkg::seg_t   seg6,
    output disp_pkg::seg_t   seg7
);

    // point stays off, hence bit 7 high in every shape
    function automatic disp_pkg::seg_t hex_to_seg(input disp_pkg::hex_t value);
        case (value)
            4'h0:    hex_to_seg = 8'hC0;
            4'h1:    hex_to_seg = 8'hF9;
            4'h2:    hex_to_seg = 8'hA4;
            4'h3:    hex_to_seg = 8'hB0;
            4'h4:    hex_to_seg = 8'h99;
            4'h5:    hex_to_seg = 8'h92;
            4'h6:    hex_to_seg = 8'h82;
            4'h7:    hex_to_seg = 8'hF8;
            4'h8:    hex_to_seg = 8'h80;
            4'h9:    hex_to_seg = 8'h90;
            4'hA:    hex_to_seg = 8'h88;
            4'hB:    hex_to_seg = 8'h83;
            4'hC:    hex_to_seg = 8'hC6;
            4'hD:    hex_to_seg = 8'hA1;
            4'hE:    hex_to_seg = 8'h86;
            default: hex_to_seg = 8'h8E;
        endcase
    endfunction

    function automatic disp_pkg::seg_t encode(input disp_pkg::digit_t digit);
        encode = digit[4] ? disp_pkg::seg_t'(`SEG_BLANK) : hex_to_seg(digit[3:0]);
    endfunction

    assign seg0 = encode(scan_lo);
    assign seg1 = encode(scan_hi);
    assign seg2 = encode(ascii_lo);
    assign seg3 = encode(ascii_hi);
    // positions 4 and 5 sit between the ascii and count pairs and stay dark
    assign seg4 = `SEG_BLANK;
    assign seg5 = `SEG_BLANK;
    assign seg6 = encode(count_lo);
    assign seg7 = encode(count_hi);

endmodule

// File: verilog/kbd_panel_top.sv
`timescale 1ns/1ns

module kbd_panel_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output disp_pkg::seg_t      seg0,
    output disp_pkg::seg_t      seg1,
    output disp_pkg::seg_t      seg2,
    output disp_pkg::seg_t      seg3,
    output disp_pkg::seg_t      seg4,
    output disp_pkg::seg_t      seg5,
    output disp_pkg::seg_t      seg6,
    output disp_pkg::seg_t      seg7,
    output kbd_pkg::scan_code_t ledr,
    output logic                frame_err
);

    kbd_pkg::scan_code_t code;
    logic                code_valid;
    logic                code_ready;
    disp_pkg::digit_t    scan_lo;
    disp_pkg::digit_t    scan_hi;
    disp_pkg::digit_t    ascii_lo;
    disp_pkg::digit_t    ascii_hi;
    disp_pkg::digit_t    count_lo;
    disp_pkg::digit_t    count_hi;

    ps2_rx u_ps2_rx (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .code       (code),
        .code_valid (code_valid),
        .code_ready (code_ready),
        .frame_err  (frame_err)
    );

    // ledr shows the most recent byte, break prefix included
    key_event u_key_event (
        .clk        (clk),
        .rst        (rst),
        .code       (code),
        .code_valid (code_valid),
        .code_ready (code_ready),
        .last_code  (ledr),
        .scan_lo    (scan_lo),
        .scan_hi    (scan_hi),
        .ascii_lo   (ascii_lo),
        .ascii_hi   (ascii_hi),
        .count_lo   (count_lo),
        .count_hi   (count_hi)
    );

    seg_display u_seg_display (
        .scan_lo  (scan_lo),
        .scan_hi  (scan_hi),
        .ascii_lo (ascii_lo),
        .ascii_hi (ascii_hi),
        .count_lo (count_lo),
        .count_hi (count_hi),
        .seg0     (seg0),
        .seg1     (seg1),
        .seg2     (seg2),
        .seg3     (seg3),
        .seg4     (seg4),
        .seg5     (seg5),
        .seg6     (seg6),
        .seg7     (seg7)
    );

endmodule

// File: verification/kbd_panel_assertions.sv
`timescale 1ns/1ns

module kbd_panel_assertions (
    input logic                clk,
    input logic                rst,
    input kbd_pkg::scan_code_t code,
    input logic                code_valid,
    input logic                code_ready,
    input logic                frame_err
);

    // the one-entry holding register empties on the transfer
    property released_after_take;
        @(posedge clk) disable iff (rst)
            code_valid && code_ready |=> !code_valid && $stable(code);
    endproperty

    property err_single_cycle;
        @(posedge clk) disable iff (rst) frame_err |=> !frame_err;
    endproperty

    // a dropped frame never reaches HOLD
    property err_not_with_valid;
        @(posedge clk) disable iff (rst) frame_err |-> !$rose(code_valid);
    endproperty

    property idle_after_reset;
        @(posedge clk) rst |=> !code_valid;
    endproperty

    a_hold: assert property (released_after_take)
        else $error("code_valid stayed high or code changed after the handshake");
    a_err_pulse: assert property (err_single_cycle)
        else $error("frame_err stayed high longer than one cycle");
    a_err_valid: assert property (err_not_with_valid)
        else $error("frame_err came together with a rising code_valid");
    a_reset: assert property (idle_after_reset)
        else $error("code_valid high in the cycle after reset");

endmodule

bind ps2_rx kbd_panel_assertions u_rx_assertions (
    .clk        (clk),
    .rst        (rst),
    .code       (code),
    .code_valid (code_valid),
    .code_ready (code_ready),
    .frame_err  (frame_err)
);

// consumer side has no frame error line
bind key_event kbd_panel_assertions u_event_assertions (
    .clk        (clk),
    .rst        (rst),
    .code       (code),
    .code_valid (code_valid),
    .code_ready (code_ready),
    .frame_err  (1'b0)
);

// File: verification/kbd_panel_tb.sv
`timescale 1ns/1ns
`include "kbd_defines.svh"

module kbd_panel_tb;

    // ps2_clk half period in clk cycles
    localparam int half_bit = 8;
    localparam int wait_limit = 4 * (`KBD_SYNC_STAGES + 3);

    logic                    clk;
    logic                    rst;
    logic                    ps2_clk;
    logic                    ps2_data;
    disp_pkg::seg_t          seg0, seg1, seg2, seg3, seg4, seg5, seg6, seg7;
    kbd_pkg::scan_code_t     ledr;
    logic                    frame_err;

    integer                  seed;
    int                      errors;
    int                      low_cycles;
    kbd_pkg::release_count_t releases;
    kbd_pkg::scan_code_t     digit_keys [10];
    disp_pkg::seg_t          shapes [16];

    kbd_panel_top u_kbd_panel_top (
        .clk       (clk),
        .rst       (rst),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .seg0      (seg0),
        .seg1      (seg1),
        .seg2      (seg2),
        .seg3      (seg3),
        .seg4      (seg4),
        .seg5      (seg5),
        .seg6      (seg6),
        .seg7      (seg7),
        .ledr      (ledr),
        .frame_err (frame_err)
    );

    always #10 clk = ~clk;

    task automatic compare(input string name, input logic [7:0] expected,
                           input logic [7:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout: %s", what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    function automatic kbd_pkg::ascii_t ascii_of(input kbd_pkg::scan_code_t sc);
        kbd_pkg::ascii_t result;
        result = 8'h00;
        for (int i = 0; i < 10; i++) begin
            if (digit_keys[i] == sc) begin
                result = 8'h30 + i[7:0];
            end
        end
        return result;
    endfunction

    // data changes only in the middle of the high phase
    task automatic send_bit(input logic b);
        ps2_data <= b;
        repeat (half_bit / 2) @(posedge clk);
        ps2_clk <= 1'b0;
        repeat (half_bit) @(posedge clk);
        ps2_clk <= 1'b1;
        repeat (half_bit / 2) @(posedge clk);
    endtask

    task automatic send_frame(input kbd_pkg::scan_code_t sc, input logic parity_ok);
        logic parity;
        parity = parity_ok ? ~^sc : ^sc;
        send_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            send_bit(sc[i]);
        end
        send_bit(parity);
        // stop bit with the clock left low for finish_frame
        ps2_data <= 1'b1;
        repeat (half_bit / 2) @(posedge clk);
        ps2_clk <= 1'b0;
    endtask

    task automatic wait_for_code(input kbd_pkg::scan_code_t sc);
        low_cycles = 0;
        while (ledr !== sc) begin
            if (low_cycles >= wait_limit) begin
                give_up("ledr never showed the sent scan code");
            end
            @(negedge clk);
            low_cycles++;
        end
    endtask

    task automatic wait_for_error();
        low_cycles = 0;
        while (frame_err !== 1'b1) begin
            if (low_cycles >= wait_limit) begin
                give_up("frame_err never pulsed for the bad frame");
            end
            @(negedge clk);
            low_cycles++;
        end
    endtask

    // ends the low half of the stop bit and idles
    task automatic finish_frame();
        int rest;
        rest = half_bit + 1 - low_cycles;
        if (rest < 1) begin
            rest = 1;
        end
        repeat (rest) @(posedge clk);
        ps2_clk <= 1'b1;
        repeat (half_bit) @(posedge clk);
    endtask

    task automatic deliver(input kbd_pkg::scan_code_t sc);
        send_frame(sc, 1'b1);
        wait_for_code(sc);
    endtask

    task automatic verify_make(input string name, input kbd_pkg::scan_code_t sc);
        kbd_pkg::ascii_t a;
        a = ascii_of(sc);
        compare({name, " ledr"}, sc, ledr);
        compare({name, " seg0"}, shapes[sc[3:0]], seg0);
        compare({name, " seg1"}, shapes[sc[7:4]], seg1);
        compare({name, " seg2"}, shapes[a[3:0]], seg2);
        compare({name, " seg3"}, shapes[a[7:4]], seg3);
    endtask

    task automatic expect_blank(input string name);
        compare({name, " seg0"}, `SEG_BLANK, seg0);
        compare({name, " seg1"}, `SEG_BLANK, seg1);
        compare({name, " seg2"}, `SEG_BLANK, seg2);
        compare({name, " seg3"}, `SEG_BLANK, seg3);
        compare({name, " seg4"}, `SEG_BLANK, seg4);
        compare({name, " seg5"}, `SEG_BLANK, seg5);
    endtask

    task automatic expect_count(input string name);
        compare({name, " seg6"}, shapes[releases[3:0]], seg6);
        compare({name, " seg7"}, shapes[releases[7:4]], seg7);
    endtask

    // F0 followed by the key code
    task automatic release_key(input kbd_pkg::scan_code_t sc);
        deliver(`KBD_BREAK_CODE);
        expect_blank("break");
        finish_frame();
        deliver(sc);
        releases = releases + 8'd1;
        expect_blank("release");
        expect_count("release");
        finish_frame();
    endtask

    initial begin
        int                  idx;
        int                  prev_idx;
        kbd_pkg::scan_code_t saved_ledr;
        logic [63:0]         saved_segs;
        logic [63:0]         now_segs;

        clk = 1'b0;
        rst <= 1'b1;
        ps2_clk <= 1'b1;
        ps2_data <= 1'b1;
        seed = 64;
        errors = 0;
        releases = '0;
        digit_keys = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25,
                       8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46};
        // active low shapes for 0 to F with the point off
        shapes = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
                   8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        expect_blank("reset");
        expect_count("reset");
        compare("reset ledr", 8'h00, ledr);

        @(posedge clk);
        deliver(8'h16);
        verify_make("digit make", 8'h16);
        finish_frame();
        deliver(8'h1C);
        verify_make("non-digit make", 8'h1C);
        finish_frame();
        release_key(8'h1C);

        // no key twice in a row so that ledr changes on every frame
        prev_idx = -1;
        for (int n = 0; n < 10; n++) begin
            idx = $unsigned($random(seed)) % 10;
            if (idx == prev_idx) begin
                idx = (idx + 1) % 10;
            end
            prev_idx = idx;
            deliver(digit_keys[idx]);
            verify_make("random make", digit_keys[idx]);
            finish_frame();
            release_key(digit_keys[idx]);
        end

        @(negedge clk);
        saved_ledr = ledr;
        saved_segs = {seg7, seg6, seg5, seg4, seg3, seg2, seg1, seg0};
        @(posedge clk);
        send_frame(8'h5A, 1'b0);
        wait_for_error();
        finish_frame();
        @(negedge clk);
        now_segs = {seg7, seg6, seg5, seg4, seg3, seg2, seg1, seg0};
        compare("bad parity ledr", saved_ledr, ledr);
        for (int i = 0; i < 8; i++) begin
            compare("bad parity seg", saved_segs[i*8 +: 8], now_segs[i*8 +: 8]);
        end

        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: kbd_panel.f
+incdir+common
common/kbd_pkg.sv
common/disp_pkg.sv
ps2_rx/ps2_rx.sv
verilog/key_event.sv
verilog/seg_display.sv
verilog/kbd_panel_top.sv
verification/kbd_panel_assertions.sv
verification/kbd_panel_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the keyboard panel testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f kbd_panel.f --top-module kbd_panel_tb \
    -o kbd_panel_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/kbd_panel_sim > sim.log 2>&1 || echo "SOME TESTS FAILED" >> sim.log
cat sim.log

grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; } || exit 0
